// ==== common/frontend_macros.svh ====
/* tunable front-end constants: reset PC, interrupt-number width and PC step.
   included by the pipeline package and by any RTL file that needs a value */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// first PC fetched after reset
`define FE_RESET_PC 32'h0000_1000

// width of the interrupt number carried with an instruction
`define FE_IRQ_NO_W 8

// byte step between sequential instructions
`define FE_PC_STEP 32'd4

`endif

// ==== common/frontend_pkg.sv ====
/* pipeline data types shared by fetch, the IF/ID register, decode and the top.
   import where PC, instruction or interrupt values cross a port */
`include "frontend_macros.svh"

package frontend_pkg;

    // program counter, byte address
    typedef logic [31:0] pc_t;

    // raw 32-bit instruction word
    typedef logic [31:0] inst_t;

    // interrupt number tagged onto an instruction
    typedef logic [`FE_IRQ_NO_W-1:0] irq_no_t;

    // fetch control, one idle cycle after reset before the first fetch
    typedef enum logic {
        FS_RESET = 1'b0,
        FS_RUN   = 1'b1
    } fetch_state_e;

endpackage

// ==== common/rv_isa_pkg.sv ====
/* RV32I instruction fields, major opcodes and the instruction classes
   produced by decode; also used by the testbench reference decoder */
package rv_isa_pkg;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // sign-extended immediate
    typedef logic [31:0] imm_t;

    // bits [6:0] of the instruction
    typedef logic [6:0] opcode_t;

    // base opcode map
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_SYSTEM,
        CLS_ILLEGAL
    } inst_class_e;

endpackage

// ==== verilog/fetch_unit.sv ====
/* instruction fetch: holds the PC, addresses the instruction memory and offers
   each word to the IF/ID register, tagged with any pending interrupt */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module fetch_unit
    import frontend_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    // instruction memory, answers in the same cycle
    output pc_t     imem_addr_o,
    input  inst_t   imem_data_i,

    input  logic    redirect_i,
    input  pc_t     redirect_pc_i,

    input  logic    irq_i,
    input  irq_no_t irq_no_i,

    // towards the IF/ID register
    output logic    valid_o,
    input  logic    ready_i,
    output pc_t     pc_o,
    output inst_t   inst_o,
    output logic    irq_o,
    output irq_no_t irq_no_o
);

    fetch_state_e state_q;
    pc_t          pc_q;
    logic         irq_pend_q;
    irq_no_t      irq_pend_no_q;
    logic         transfer;

    // nothing is offered while the PC is being redirected
    assign valid_o  = (state_q == FS_RUN) && !redirect_i;
    assign transfer = valid_o && ready_i;

    assign imem_addr_o = pc_q;
    assign pc_o        = pc_q;
    assign inst_o      = imem_data_i;

    // a pulse in this cycle rides along at once and wins over the latched number
    assign irq_o    = irq_pend_q || irq_i;
    assign irq_no_o = irq_i ? irq_no_i : irq_pend_no_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= FS_RESET;
            pc_q    <= `FE_RESET_PC;
        end else begin
            state_q <= FS_RUN;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (transfer) begin
                pc_q <= pc_q + `FE_PC_STEP;
            end
        end
    end

    // pending interrupt, cleared once it leaves with an instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_pend_q <= 1'b0;
        end else if (transfer) begin
            irq_pend_q <= 1'b0;
        end else if (irq_i) begin
            irq_pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (irq_i) begin
            irq_pend_no_q <= irq_no_i;
        end
    end

endmodule

// ==== verilog/if_id_reg.sv ====
/* IF/ID stage register: one instruction held under valid/ready,
   cleared by a flush when the PC is redirected */
`timescale 1ns/100ps

module if_id_reg
    import frontend_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  logic    flush_i,

    // from fetch
    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  pc_t     pc_i,
    input  inst_t   inst_i,
    input  logic    irq_i,
    input  irq_no_t irq_no_i,

    // to decode
    output logic    out_valid_o,
    input  logic    out_ready_i,
    output pc_t     pc_o,
    output inst_t   inst_o,
    output logic    irq_o,
    output irq_no_t irq_no_o
);

    logic    valid_q;
    logic    irq_q;
    pc_t     pc_q;
    inst_t   inst_q;
    irq_no_t irq_no_q;

    // take a new word when empty or when the held one drains this cycle
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign pc_o        = pc_q;
    assign inst_o      = inst_q;
    assign irq_o       = irq_q;
    assign irq_no_o    = irq_no_q;

    // flush beats acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            irq_q   <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            irq_q   <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                irq_q <= irq_i;
            end
        end
    end

    // payload only moves on an accepted valid word
    always_ff @(posedge clk) begin
        if (!flush_i && in_ready_o && in_valid_i) begin
            pc_q     <= pc_i;
            inst_q   <= inst_i;
            irq_no_q <= irq_no_i;
        end
    end

endmodule

// ==== verilog/decode_unit.sv ====
/* combinational RV32I decode of the held instruction: register indices,
   immediate, class and an illegal flag; valid/ready pass straight through */
`timescale 1ns/100ps

module decode_unit
    import frontend_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic        valid_i,
    input  inst_t       inst_i,
    output logic        ready_o,

    output logic        valid_o,
    input  logic        ready_i,
    output reg_idx_t    rd_o,
    output reg_idx_t    rs1_o,
    output reg_idx_t    rs2_o,
    output imm_t        imm_o,
    output inst_class_e class_o,
    output logic        illegal_o
);

    opcode_t opcode;
    imm_t    imm_i_fmt;
    imm_t    imm_s_fmt;
    imm_t    imm_b_fmt;
    imm_t    imm_u_fmt;
    imm_t    imm_j_fmt;

    assign valid_o = valid_i;
    assign ready_o = ready_i;

    assign opcode = inst_i[6:0];
    assign rd_o   = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    // immediate formats, all sign-extended from bit 31
    assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_u_fmt = {inst_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb begin
        illegal_o = 1'b0;
        imm_o     = '0;
        case (opcode)
            OPC_LUI: begin
                class_o = CLS_LUI;
                imm_o   = imm_u_fmt;
            end
            OPC_AUIPC: begin
                class_o = CLS_AUIPC;
                imm_o   = imm_u_fmt;
            end
            OPC_JAL: begin
                class_o = CLS_JAL;
                imm_o   = imm_j_fmt;
            end
            OPC_JALR: begin
                class_o = CLS_JALR;
                imm_o   = imm_i_fmt;
            end
            OPC_BRANCH: begin
                class_o = CLS_BRANCH;
                imm_o   = imm_b_fmt;
            end
            OPC_LOAD: begin
                class_o = CLS_LOAD;
                imm_o   = imm_i_fmt;
            end
            OPC_STORE: begin
                class_o = CLS_STORE;
                imm_o   = imm_s_fmt;
            end
            OPC_OP_IMM: begin
                class_o = CLS_OP_IMM;
                imm_o   = imm_i_fmt;
            end
            // register-register ops carry no immediate
            OPC_OP: begin
                class_o = CLS_OP;
            end
            OPC_SYSTEM: begin
                class_o = CLS_SYSTEM;
                imm_o   = imm_i_fmt;
            end
            default: begin
                class_o   = CLS_ILLEGAL;
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/frontend_top.sv ====
/* front end of the core: fetch, IF/ID register and decode in a row.
   memory, redirect and interrupt inputs in, decoded instruction out */
`timescale 1ns/100ps

module frontend_top
    import frontend_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    output pc_t         imem_addr_o,
    input  inst_t       imem_data_i,

    input  logic        redirect_i,
    input  pc_t         redirect_pc_i,

    input  logic        irq_i,
    input  irq_no_t     irq_no_i,

    output logic        dec_valid_o,
    input  logic        dec_ready_i,
    output pc_t         dec_pc_o,
    output reg_idx_t    dec_rd_o,
    output reg_idx_t    dec_rs1_o,
    output reg_idx_t    dec_rs2_o,
    output imm_t        dec_imm_o,
    output inst_class_e dec_class_o,
    output logic        dec_illegal_o,
    output logic        dec_irq_o,
    output irq_no_t     dec_irq_no_o
);

    // fetch to stage register
    logic    fe_valid;
    logic    fe_ready;
    pc_t     fe_pc;
    inst_t   fe_inst;
    logic    fe_irq;
    irq_no_t fe_irq_no;

    // stage register to decode
    logic    id_valid;
    logic    id_ready;
    inst_t   id_inst;

    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .irq_i         (irq_i),
        .irq_no_i      (irq_no_i),
        .valid_o       (fe_valid),
        .ready_i       (fe_ready),
        .pc_o          (fe_pc),
        .inst_o        (fe_inst),
        .irq_o         (fe_irq),
        .irq_no_o      (fe_irq_no)
    );

    // a redirect also drops whatever the stage register holds
    if_id_reg u_if_id (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (redirect_i),
        .in_valid_i  (fe_valid),
        .in_ready_o  (fe_ready),
        .pc_i        (fe_pc),
        .inst_i      (fe_inst),
        .irq_i       (fe_irq),
        .irq_no_i    (fe_irq_no),
        .out_valid_o (id_valid),
        .out_ready_i (id_ready),
        .pc_o        (dec_pc_o),
        .inst_o      (id_inst),
        .irq_o       (dec_irq_o),
        .irq_no_o    (dec_irq_no_o)
    );

    decode_unit u_decode (
        .valid_i   (id_valid),
        .inst_i    (id_inst),
        .ready_o   (id_ready),
        .valid_o   (dec_valid_o),
        .ready_i   (dec_ready_i),
        .rd_o      (dec_rd_o),
        .rs1_o     (dec_rs1_o),
        .rs2_o     (dec_rs2_o),
        .imm_o     (dec_imm_o),
        .class_o   (dec_class_o),
        .illegal_o (dec_illegal_o)
    );

endmodule

// ==== sim/frontend_assert.sv ====
/* concurrent checks on the front end's decode handshake, stall and redirect
   behaviour; bound into every frontend_top instance */
`timescale 1ns/100ps

module frontend_assert
    import frontend_pkg::*;
    import rv_isa_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input pc_t         imem_addr_o,
    input logic        redirect_i,
    input logic        dec_valid_o,
    input logic        dec_ready_i,
    input pc_t         dec_pc_o,
    input reg_idx_t    dec_rd_o,
    input reg_idx_t    dec_rs1_o,
    input reg_idx_t    dec_rs2_o,
    input imm_t        dec_imm_o,
    input inst_class_e dec_class_o,
    input logic        dec_illegal_o,
    input logic        dec_irq_o,
    input irq_no_t     dec_irq_no_o
);

    int unsigned fail_count = 0;

    // nothing valid comes out of a reset cycle
    reset_quiet: assert property (@(posedge clk) reset |=> !dec_valid_o && !dec_irq_o)
        else begin
            $error("decode output valid right after a reset cycle");
            fail_count++;
        end

    // a stalled instruction stays put
    stall_stable: assert property (@(posedge clk) disable iff (reset)
        dec_valid_o && !dec_ready_i && !redirect_i |=>
            dec_valid_o && $stable(dec_pc_o) && $stable(dec_rd_o) && $stable(dec_rs1_o) &&
            $stable(dec_rs2_o) && $stable(dec_imm_o) && $stable(dec_class_o) &&
            $stable(dec_illegal_o) && $stable(dec_irq_o) &&
            (!dec_irq_o || $stable(dec_irq_no_o)))
        else begin
            $error("decoded outputs changed under a stall");
            fail_count++;
        end

    // fetch holds its PC while both stages are blocked
    stall_pc_held: assert property (@(posedge clk) disable iff (reset)
        dec_valid_o && !dec_ready_i && !redirect_i |=> $stable(imem_addr_o))
        else begin
            $error("fetch address moved while the stage register was blocked");
            fail_count++;
        end

    redirect_flush: assert property (@(posedge clk) disable iff (reset)
        redirect_i |=> !dec_valid_o)
        else begin
            $error("decode output valid in the cycle after a redirect");
            fail_count++;
        end

endmodule

bind frontend_top frontend_assert u_assert (.*);

// ==== sim/frontend_tb.sv ====
/* front-end testbench with a table-driven instruction memory and random stalls,
   redirects and interrupts. an in-order reference model checks every transfer */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module frontend_tb
    import frontend_pkg::*;
    import rv_isa_pkg::*;
();

    logic        clk = 1'b0;
    logic        reset;
    pc_t         imem_addr_o;
    inst_t       imem_data_i;
    logic        redirect_i;
    pc_t         redirect_pc_i;
    logic        irq_i;
    irq_no_t     irq_no_i;
    logic        dec_valid_o;
    logic        dec_ready_i;
    pc_t         dec_pc_o;
    reg_idx_t    dec_rd_o;
    reg_idx_t    dec_rs1_o;
    reg_idx_t    dec_rs2_o;
    imm_t        dec_imm_o;
    inst_class_e dec_class_o;
    logic        dec_illegal_o;
    logic        dec_irq_o;
    irq_no_t     dec_irq_no_o;

    // reference model state
    pc_t         exp_pc;
    pc_t         fetch_pc;
    logic        pend;
    irq_no_t     pend_no;
    logic        stage_irq;
    irq_no_t     stage_no;
    int          low_cycles;
    int          xfer_count = 0;
    int          errors = 0;
    int          timeouts = 0;

    always #20 clk = ~clk;

    frontend_top dut0 (.*);

    // scrambles the whole address into the table fields
    function automatic logic [31:0] hash_pc(input pc_t pc);
        return (pc * 32'h9e37_79b9) ^ (pc >> 5);
    endfunction

    // opcodes outside the RV32I base map
    function automatic opcode_t bad_opcode(input logic [2:0] sel);
        case (sel)
            3'b010:  return 7'b0000000;
            3'b011:  return 7'b0001111;
            3'b100:  return 7'b1111111;
            3'b101:  return 7'b1010011;
            3'b110:  return 7'b0101111;
            default: return 7'b0001011;
        endcase
    endfunction

    // ten legal classes followed by six illegal words
    function automatic inst_class_e table_class(input pc_t pc);
        if (pc[5:2] < 4'd10) begin
            return inst_class_e'(pc[5:2]);
        end
        return CLS_ILLEGAL;
    endfunction

    // immediate chosen per format within its legal range
    function automatic imm_t table_imm(input pc_t pc);
        logic [31:0] h;
        h = hash_pc(pc);
        case (table_class(pc))
            CLS_LUI, CLS_AUIPC: return {h[31:12], 12'b0};
            CLS_JAL:            return {{11{h[31]}}, h[31:12], 1'b0};
            CLS_BRANCH:         return {{19{h[31]}}, h[31:20], 1'b0};
            CLS_JALR, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_SYSTEM:
                return {{20{h[31]}}, h[31:20]};
            default:            return '0;
        endcase
    endfunction

    // encodes the chosen fields into an instruction word
    function automatic inst_t table_word(input pc_t pc);
        logic [31:0] h;
        imm_t        imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        h   = hash_pc(pc);
        imm = table_imm(pc);
        rd  = h[4:0];
        rs1 = h[9:5];
        rs2 = h[14:10];
        f3  = h[17:15];
        case (table_class(pc))
            CLS_LUI:    return {imm[31:12], rd, OPC_LUI};
            CLS_AUIPC:  return {imm[31:12], rd, OPC_AUIPC};
            CLS_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            CLS_JALR:   return {imm[11:0], rs1, f3, rd, OPC_JALR};
            CLS_BRANCH: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                                OPC_BRANCH};
            CLS_LOAD:   return {imm[11:0], rs1, f3, rd, OPC_LOAD};
            CLS_STORE:  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
            CLS_OP_IMM: return {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
            CLS_OP:     return {h[31:25], rs2, rs1, f3, rd, OPC_OP};
            CLS_SYSTEM: return {imm[11:0], rs1, f3, rd, OPC_SYSTEM};
            default:    return {h[31:7], bad_opcode(pc[4:2])};
        endcase
    endfunction

    // instruction memory model answering in the same cycle
    assign imem_data_i = table_word(imem_addr_o);

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // outputs settle by the falling edge and the transfer happens on the next rising one
    always @(negedge clk) begin
        inst_t word;
        logic  fetch_xfer;
        if (reset) begin
            exp_pc     = `FE_RESET_PC;
            fetch_pc   = `FE_RESET_PC;
            pend       = 1'b0;
            stage_irq  = 1'b0;
            low_cycles = 0;
        end else begin
            compare_field("imem_addr_o", imem_addr_o, fetch_pc);
            if (dec_valid_o && dec_ready_i) begin
                word = table_word(exp_pc);
                compare_field("dec_pc_o", dec_pc_o, exp_pc);
                compare_field("dec_rd_o", dec_rd_o, word[11:7]);
                compare_field("dec_rs1_o", dec_rs1_o, word[19:15]);
                compare_field("dec_rs2_o", dec_rs2_o, word[24:20]);
                compare_field("dec_imm_o", dec_imm_o, table_imm(exp_pc));
                compare_field("dec_class_o", dec_class_o, table_class(exp_pc));
                compare_field("dec_illegal_o", dec_illegal_o,
                              table_class(exp_pc) == CLS_ILLEGAL);
                compare_field("dec_irq_o", dec_irq_o, stage_irq);
                if (stage_irq) begin
                    compare_field("dec_irq_no_o", dec_irq_no_o, stage_no);
                end
                exp_pc = exp_pc + 32'd4;
                xfer_count++;
            end
            // a pulse joins the pending record at once and replaces its number
            if (irq_i) begin
                pend    = 1'b1;
                pend_no = irq_no_i;
            end
            fetch_xfer = (low_cycles > 0) && !redirect_i && (!dec_valid_o || dec_ready_i);
            if (redirect_i) begin
                exp_pc    = redirect_pc_i;
                fetch_pc  = redirect_pc_i;
                stage_irq = 1'b0;
            end else if (fetch_xfer) begin
                fetch_pc  = fetch_pc + 32'd4;
                stage_irq = pend;
                stage_no  = pend_no;
                pend      = 1'b0;
            end
            low_cycles++;
        end
    end

    task automatic drive_random_inputs();
        dec_ready_i   = ($urandom % 4) != 0;
        redirect_i    = ($urandom % 24) == 0;
        redirect_pc_i = `FE_RESET_PC + (($urandom % 512) * 4);
        irq_i         = ($urandom % 12) == 0;
        irq_no_i      = irq_no_t'($urandom);
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h3b0e_eaa9));
        reset         = 1'b1;
        dec_ready_i   = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        irq_i         = 1'b0;
        irq_no_i      = '0;
        repeat (4) @(posedge clk);
        #2;
        reset       = 1'b0;
        dec_ready_i = 1'b1;

        // first word after reset comes without stalls
        cycles = 0;
        while (xfer_count == 0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (xfer_count == 0) begin
            timeouts++;
            $display("timeout: no instruction left decode after reset");
        end

        cycles = 0;
        while (xfer_count < 400 && cycles < 4000) begin
            @(posedge clk);
            #2;
            drive_random_inputs();
            cycles++;
        end
        if (xfer_count < 400) begin
            timeouts++;
            $display("timeout: only %0d instructions left decode", xfer_count);
        end

        $display("transfers %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
                 xfer_count, errors, dut0.u_assert.fail_count, timeouts);
        if (errors == 0 && dut0.u_assert.fail_count == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/frontend_pkg.sv
common/rv_isa_pkg.sv
verilog/fetch_unit.sv
verilog/if_id_reg.sv
verilog/decode_unit.sv
verilog/frontend_top.sv
sim/frontend_assert.sv
sim/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: rv_frontend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/frontend_pkg.sv
      - common/rv_isa_pkg.sv
      - verilog/fetch_unit.sv
      - verilog/if_id_reg.sv
      - verilog/decode_unit.sv
      - verilog/frontend_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/frontend_assert.sv
      - sim/frontend_tb.sv
